// File: dv/mips_checker.sv
`timescale 1ns/10ps

module mips_checker (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_valid,
  input  logic [31:0] wb_pc,
  input  logic        exp_pc_we,
  input  logic [31:0] exp_pc,
  input  logic        rf_check,
  input  logic [4:0]  rf_addr,
  input  logic [31:0] rf_data,
  input  logic [31:0] rf_exp,
  input  logic        mem_check,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_data,
  input  logic [31:0] mem_exp,
  output logic        done,
  output int          value_errs,
  output int          retire_errs
);

  logic [31:0] pc_queue [$];
  logic [31:0] last_pc = '0;
  logic [31:0] expected = '0;
  logic        done_q = 1'b0;
  int          pushed = 0;
  int          retired = 0;
  int          value_cnt = 0;
  int          retire_cnt = 0;

  assign done        = done_q;
  assign value_errs  = value_cnt;
  assign retire_errs = retire_cnt;

  // expected path arrives while the program loads
  // last entry is the final loop
  always @(posedge clk) begin
    if (exp_pc_we) begin
      pc_queue.push_back(exp_pc);
      pushed++;
      last_pc = exp_pc;
    end
    if (!reset && wb_valid) begin
      if (!done_q) begin
        retired++;
        if (pc_queue.size() == 0) begin
          retire_cnt++;
          $display("[ERROR] %0t: pc %h retired beyond the expected path", $time, wb_pc);
        end else begin
          expected = pc_queue.pop_front();
          if (wb_pc !== expected) begin
            retire_cnt++;
            $display("[ERROR] %0t: retired pc %h, expected %h", $time, wb_pc, expected);
          end
        end
        if (wb_pc == last_pc) begin
          done_q = 1'b1;
          if (retired != pushed) begin
            retire_cnt++;
            $display("[ERROR] %0t: %0d retirements, expected %0d", $time, retired, pushed);
          end
        end
      end else if (wb_pc != last_pc && wb_pc != last_pc + 32'd4) begin
        // only the loop jump and its slot may retire now
        retire_cnt++;
        $display("[ERROR] %0t: pc %h retired after the final loop", $time, wb_pc);
      end
    end
  end

  always @(posedge clk) begin
    if (rf_check && rf_data !== rf_exp) begin
      value_cnt++;
      $display("[ERROR] %0t: register %0d reads %h, expected %h", $time, rf_addr, rf_data,
               rf_exp);
    end
    if (mem_check && mem_data !== mem_exp) begin
      value_cnt++;
      $display("[ERROR] %0t: memory %h reads %h, expected %h", $time, mem_addr, mem_data,
               mem_exp);
    end
  end

endmodule

// File: dv/mips_tb.sv
`timescale 1ns/10ps

module mips_tb;

  localparam int clk_period   = 40;
  localparam int reset_cycles = 4;
  localparam int max_prog     = 64;

  logic        clk;
  logic        reset;
  logic        imem_we;
  logic [31:0] imem_addr;
  logic [31:0] imem_wdata;
  logic [4:0]  rf_addr;
  logic [31:0] rf_data;
  logic [31:0] mem_addr;
  logic [31:0] mem_data;
  logic [31:0] wb_pc;
  logic        wb_valid;
  logic        exp_pc_we;
  logic [31:0] exp_pc;
  logic        rf_check;
  logic        mem_check;
  logic [31:0] rf_exp;
  logic [31:0] mem_exp;
  logic        done;
  int          value_errs;
  int          retire_errs;
  logic        running = 1'b0;

  // program words and whether each retires before the final loop
  logic [31:0] prog_word [max_prog];
  logic        prog_on_path [max_prog];
  int          prog_len = 0;
  logic [31:0] exp_reg [32];
  logic [31:0] mem_chk_addr [2];
  logic [31:0] mem_chk_val [2];
  logic [31:0] lfsr = 32'hd39;

  mips_top dut (
    .clk, .reset, .imem_we, .imem_addr, .imem_wdata,
    .rf_addr, .rf_data, .mem_addr, .mem_data, .wb_pc, .wb_valid
  );

  mips_checker chk (
    .clk, .reset, .wb_valid, .wb_pc, .exp_pc_we, .exp_pc,
    .rf_check, .rf_addr, .rf_data, .rf_exp,
    .mem_check, .mem_addr, .mem_data, .mem_exp,
    .done, .value_errs, .retire_errs
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic next_rand_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] rand_imm16();
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < 16; k++) begin
      v = {v[14:0], next_rand_bit()};
    end
    return v;
  endfunction

  function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic logic [31:0] rtype(input logic [5:0] fn, input int rd, input int rs,
                                        input int rt, input int sh);
    return {mips_pkg::op_special, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic logic [31:0] itype(input logic [5:0] op, input int rt, input int rs,
                                        input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  // offset counts words from the delay slot
  function automatic logic [31:0] branch_to(input logic [5:0] op, input int rs, input int rt,
                                            input int from, input int to);
    return itype(op, rt, rs, 16'(to - from - 1));
  endfunction

  function automatic logic [31:0] jump_to(input logic [5:0] op, input int idx);
    return {op, 26'(idx)};
  endfunction

  task automatic append_instr(input logic [31:0] word, input logic on_path);
    prog_word[prog_len]    = word;
    prog_on_path[prog_len] = on_path;
    prog_len++;
  endtask

  task automatic build_program();
    logic [15:0] imm1;
    logic [15:0] imm2;
    imm1 = rand_imm16();
    imm2 = rand_imm16();
    for (int i = 0; i < 32; i++) begin
      exp_reg[i] = '0;
    end
    append_instr(itype(mips_pkg::op_addiu, 1, 0, imm1), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 2, 0, imm2), 1'b1);
    append_instr(rtype(mips_pkg::fn_addu, 3, 1, 2, 0), 1'b1);
    append_instr(rtype(mips_pkg::fn_subu, 4, 3, 1, 0), 1'b1);
    append_instr(rtype(mips_pkg::fn_and, 5, 1, 2, 0), 1'b1);
    append_instr(rtype(mips_pkg::fn_or, 6, 1, 2, 0), 1'b1);
    append_instr(rtype(mips_pkg::fn_slt, 7, 1, 2, 0), 1'b1);
    append_instr(rtype(mips_pkg::fn_sll, 8, 0, 2, 4), 1'b1);
    append_instr(itype(mips_pkg::op_lui, 9, 0, 16'h1234), 1'b1);
    append_instr(itype(mips_pkg::op_ori, 9, 9, 16'h5678), 1'b1);
    append_instr(itype(mips_pkg::op_sw, 9, 0, 16'd16), 1'b1);
    append_instr(itype(mips_pkg::op_lw, 10, 0, 16'd16), 1'b1);
    // load-use on $10
    append_instr(rtype(mips_pkg::fn_addu, 11, 10, 1, 0), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 12, 0, 16'd5), 1'b1);
    append_instr(branch_to(mips_pkg::op_bne, 12, 0, 14, 17), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 13, 0, 16'd7), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 14, 0, 16'd1), 1'b0);
    append_instr(itype(mips_pkg::op_lw, 15, 0, 16'd16), 1'b1);
    // compare on a load still in EX
    append_instr(branch_to(mips_pkg::op_beq, 15, 9, 18, 21), 1'b1);
    append_instr(rtype(mips_pkg::fn_or, 16, 15, 0, 0), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 17, 0, 16'd1), 1'b0);
    append_instr(branch_to(mips_pkg::op_beq, 13, 0, 21, 35), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 18, 0, 16'd3), 1'b1);
    append_instr(branch_to(mips_pkg::op_bne, 16, 9, 23, 35), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 19, 0, 16'd4), 1'b1);
    append_instr(itype(mips_pkg::op_lw, 20, 0, 16'd16), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 21, 0, 16'd9), 1'b1);
    // load now in MEM
    append_instr(branch_to(mips_pkg::op_beq, 20, 9, 27, 30), 1'b1);
    append_instr(rtype(mips_pkg::fn_addu, 22, 21, 21, 0), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 23, 0, 16'd1), 1'b0);
    append_instr(jump_to(mips_pkg::op_jal, 33), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 24, 0, 16'd6), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 25, 0, 16'd1), 1'b0);
    append_instr(jump_to(mips_pkg::op_j, 36), 1'b1);
    append_instr(rtype(mips_pkg::fn_addu, 26, 31, 0, 0), 1'b1);
    append_instr(itype(mips_pkg::op_addiu, 27, 0, 16'd1), 1'b0);
    append_instr(itype(mips_pkg::op_sw, 3, 0, 16'd20), 1'b1);
    append_instr(jump_to(mips_pkg::op_j, 37), 1'b1);
    append_instr(rtype(mips_pkg::fn_sll, 0, 0, 0, 0), 1'b0);

    exp_reg[1]  = sext16(imm1);
    exp_reg[2]  = sext16(imm2);
    exp_reg[3]  = exp_reg[1] + exp_reg[2];
    exp_reg[4]  = exp_reg[3] - exp_reg[1];
    exp_reg[5]  = exp_reg[1] & exp_reg[2];
    exp_reg[6]  = exp_reg[1] | exp_reg[2];
    exp_reg[7]  = ($signed(exp_reg[1]) < $signed(exp_reg[2])) ? 32'd1 : 32'd0;
    exp_reg[8]  = exp_reg[2] << 4;
    exp_reg[9]  = {16'h1234, 16'h0000} | 32'h0000_5678;
    exp_reg[10] = exp_reg[9];
    exp_reg[11] = exp_reg[10] + exp_reg[1];
    exp_reg[12] = 32'd5;
    exp_reg[13] = 32'd7;
    exp_reg[15] = exp_reg[9];
    exp_reg[16] = exp_reg[15];
    exp_reg[18] = 32'd3;
    exp_reg[19] = 32'd4;
    exp_reg[20] = exp_reg[9];
    exp_reg[21] = 32'd9;
    exp_reg[22] = exp_reg[21] + exp_reg[21];
    exp_reg[24] = 32'd6;
    // jal at word 30 links to the word after its slot
    exp_reg[31] = 32'(30 * 4 + 8);
    exp_reg[26] = exp_reg[31];
    mem_chk_addr[0] = 32'd16;
    mem_chk_val[0]  = exp_reg[9];
    mem_chk_addr[1] = 32'd20;
    mem_chk_val[1]  = exp_reg[3];
  endtask

  initial begin
    reset      = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    rf_addr    = '0;
    mem_addr   = '0;
    exp_pc_we  = 1'b0;
    exp_pc     = '0;
    rf_check   = 1'b0;
    mem_check  = 1'b0;
    rf_exp     = '0;
    mem_exp    = '0;
    build_program();
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clk);
      imem_we    = 1'b1;
      imem_addr  = 32'(i * 4);
      imem_wdata = prog_word[i];
      exp_pc_we  = prog_on_path[i];
      exp_pc     = 32'(i * 4);
    end
    @(negedge clk);
    imem_we   = 1'b0;
    exp_pc_we = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    reset   = 1'b0;
    running = 1'b1;
    wait (done);
    @(negedge clk);
    for (int i = 0; i < 32; i++) begin
      @(negedge clk);
      rf_check = 1'b1;
      rf_addr  = 5'(i);
      rf_exp   = exp_reg[i];
    end
    @(negedge clk);
    rf_check = 1'b0;
    for (int i = 0; i < 2; i++) begin
      mem_check = 1'b1;
      mem_addr  = mem_chk_addr[i];
      mem_exp   = mem_chk_val[i];
      @(negedge clk);
    end
    mem_check = 1'b0;
    @(negedge clk);
    $display("checks done: %0d value errors, %0d retire errors", value_errs, retire_errs);
    if (value_errs + retire_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // program run bounded by its length
  initial begin
    wait (running);
    repeat (prog_len * 4 + 50) @(posedge clk);
    if (!done) begin
      $display("program never reached its final loop within %0d cycles", prog_len * 4 + 50);
      $display("Test failed");
      $finish;
    end
  end

endmodule

// File: logic/decode_unit.sv
`timescale 1ns/10ps

module decode_unit (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [mips_pkg::xlen-1:0]       id_instr,
  input  logic [mips_pkg::xlen-1:0]       id_pc,
  input  logic                            id_valid,
  input  logic                            stall,
  input  logic                            br_fwd_a,
  input  logic                            br_fwd_b,
  output logic                            br_taken,
  output logic [mips_pkg::xlen-1:0]       br_target,
  input  logic [mips_pkg::reg_addr_w-1:0] rf_addr,
  output logic [mips_pkg::xlen-1:0]       rf_data,
  id_ex_if.producer                       id_ex,
  ex_mem_if.monitor                       ex_mem,
  mem_wb_if.consumer                      mem_wb
);

  mips_pkg::opcode_e               opcode;
  mips_pkg::funct_e                funct;
  logic [mips_pkg::reg_addr_w-1:0] rs;
  logic [mips_pkg::reg_addr_w-1:0] rt;
  logic [mips_pkg::reg_addr_w-1:0] rd;
  logic [mips_pkg::imm_w-1:0]      imm;
  logic [mips_pkg::xlen-1:0]       regs [32];
  logic [mips_pkg::xlen-1:0]       rd_a;
  logic [mips_pkg::xlen-1:0]       rd_b;
  logic [mips_pkg::xlen-1:0]       cmp_a;
  logic [mips_pkg::xlen-1:0]       cmp_b;
  logic [mips_pkg::xlen-1:0]       pc_plus4;
  logic [mips_pkg::xlen-1:0]       imm_ext;
  logic [mips_pkg::reg_addr_w-1:0] dest;
  mips_pkg::alu_op_e               alu_op;
  logic                            alu_src_imm;
  logic                            wr;
  logic                            mem_rd;
  logic                            mem_wr;
  logic                            is_jal;

  assign opcode   = mips_pkg::opcode_e'(id_instr[mips_pkg::op_lsb +: 6]);
  assign funct    = mips_pkg::funct_e'(id_instr[5:0]);
  assign rs       = id_instr[mips_pkg::rs_lsb +: mips_pkg::reg_addr_w];
  assign rt       = id_instr[mips_pkg::rt_lsb +: mips_pkg::reg_addr_w];
  assign rd       = id_instr[mips_pkg::rd_lsb +: mips_pkg::reg_addr_w];
  assign imm      = id_instr[mips_pkg::imm_w-1:0];
  assign pc_plus4 = id_pc + 32'd4;

  // register file with write-through from write-back
  assign rd_a    = (mem_wb.reg_wr && mem_wb.dest == rs) ? mem_wb.wdata : regs[rs];
  assign rd_b    = (mem_wb.reg_wr && mem_wb.dest == rt) ? mem_wb.wdata : regs[rt];
  assign rf_data = regs[rf_addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (mem_wb.reg_wr) begin
      regs[mem_wb.dest] <= mem_wb.wdata;
    end
  end

  // branch compare may take the MEM ALU result
  assign cmp_a = br_fwd_a ? ex_mem.alu_result : rd_a;
  assign cmp_b = br_fwd_b ? ex_mem.alu_result : rd_b;

  always_comb begin
    dest        = rt;
    alu_op      = mips_pkg::alu_add;
    alu_src_imm = 1'b1;
    imm_ext     = {{16{imm[15]}}, imm};
    wr          = 1'b0;
    mem_rd      = 1'b0;
    mem_wr      = 1'b0;
    is_jal      = 1'b0;
    br_taken    = 1'b0;
    br_target   = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    case (opcode)
      mips_pkg::op_special: begin
        dest        = rd;
        alu_src_imm = 1'b0;
        wr          = 1'b1;
        case (funct)
          mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
          mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
          mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
          mips_pkg::fn_sll:  alu_op = mips_pkg::alu_sll;
          default:           wr = 1'b0;
        endcase
      end
      mips_pkg::op_addiu: wr = 1'b1;
      mips_pkg::op_ori: begin
        wr      = 1'b1;
        alu_op  = mips_pkg::alu_or;
        imm_ext = {16'h0, imm};
      end
      mips_pkg::op_lui: begin
        wr     = 1'b1;
        alu_op = mips_pkg::alu_lui;
      end
      mips_pkg::op_lw: begin
        wr     = 1'b1;
        mem_rd = 1'b1;
      end
      mips_pkg::op_sw:  mem_wr = 1'b1;
      mips_pkg::op_beq: br_taken = (cmp_a == cmp_b);
      mips_pkg::op_bne: br_taken = (cmp_a != cmp_b);
      mips_pkg::op_j, mips_pkg::op_jal: begin
        br_taken  = 1'b1;
        br_target = {pc_plus4[31:28], id_instr[mips_pkg::target_w-1:0], 2'b00};
        if (opcode == mips_pkg::op_jal) begin
          // link value passes through the ALU as pc+8 plus zero
          wr      = 1'b1;
          dest    = 5'd31;
          is_jal  = 1'b1;
          imm_ext = '0;
        end
      end
      default: ;
    endcase
  end

  // ID/EX register takes a bubble on stall
  always_ff @(posedge clk) begin
    if (reset || stall) begin
      id_ex.valid  <= 1'b0;
      id_ex.reg_wr <= 1'b0;
      id_ex.mem_rd <= 1'b0;
      id_ex.mem_wr <= 1'b0;
    end else begin
      id_ex.valid  <= id_valid;
      id_ex.reg_wr <= wr && dest != '0;
      id_ex.mem_rd <= mem_rd;
      id_ex.mem_wr <= mem_wr;
    end
  end

  always_ff @(posedge clk) begin
    id_ex.rs          <= is_jal ? '0 : rs;
    id_ex.rt          <= is_jal ? '0 : rt;
    id_ex.dest        <= dest;
    id_ex.a           <= is_jal ? id_pc + 32'd8 : rd_a;
    id_ex.b           <= rd_b;
    id_ex.imm         <= imm_ext;
    id_ex.shamt       <= id_instr[mips_pkg::shamt_lsb +: 5];
    id_ex.alu_op      <= alu_op;
    id_ex.alu_src_imm <= alu_src_imm;
    id_ex.pc          <= id_pc;
  end

  a_no_r0_write: assert property (
    @(posedge clk) disable iff (reset) mem_wb.reg_wr |-> mem_wb.dest != '0
  ) else $error("write-back targets register 0");

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
  input  logic       clk,
  input  logic       reset,
  id_ex_if.consumer  id_ex,
  ex_mem_if.producer ex_mem,
  mem_wb_if.consumer mem_wb
);

  mips_pkg::fwd_sel_e        sel_a;
  mips_pkg::fwd_sel_e        sel_b;
  logic [mips_pkg::xlen-1:0] op_a;
  logic [mips_pkg::xlen-1:0] reg_b;
  logic [mips_pkg::xlen-1:0] op_b;
  logic [mips_pkg::xlen-1:0] result;

  // MEM is younger than WB, so it wins
  function automatic mips_pkg::fwd_sel_e fwd_src(input logic [mips_pkg::reg_addr_w-1:0] src);
    if (ex_mem.reg_wr && ex_mem.dest == src) begin
      return mips_pkg::fwd_mem;
    end else if (mem_wb.reg_wr && mem_wb.dest == src) begin
      return mips_pkg::fwd_wb;
    end
    return mips_pkg::fwd_rf;
  endfunction

  function automatic logic [mips_pkg::xlen-1:0] fwd_val(input mips_pkg::fwd_sel_e sel,
                                                        input logic [mips_pkg::xlen-1:0] rf);
    case (sel)
      mips_pkg::fwd_mem: return ex_mem.alu_result;
      mips_pkg::fwd_wb:  return mem_wb.wdata;
      default:           return rf;
    endcase
  endfunction

  assign sel_a = fwd_src(id_ex.rs);
  assign sel_b = fwd_src(id_ex.rt);
  assign op_a  = fwd_val(sel_a, id_ex.a);
  assign reg_b = fwd_val(sel_b, id_ex.b);
  assign op_b  = id_ex.alu_src_imm ? id_ex.imm : reg_b;

  always_comb begin
    case (id_ex.alu_op)
      mips_pkg::alu_add: result = op_a + op_b;
      mips_pkg::alu_sub: result = op_a - op_b;
      mips_pkg::alu_and: result = op_a & op_b;
      mips_pkg::alu_or:  result = op_a | op_b;
      mips_pkg::alu_slt: result = {31'h0, $signed(op_a) < $signed(op_b)};
      mips_pkg::alu_sll: result = op_b << id_ex.shamt;
      mips_pkg::alu_lui: result = {op_b[15:0], 16'h0};
      default:           result = '0;
    endcase
  end

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.valid  <= 1'b0;
      ex_mem.reg_wr <= 1'b0;
      ex_mem.mem_rd <= 1'b0;
      ex_mem.mem_wr <= 1'b0;
    end else begin
      ex_mem.valid  <= id_ex.valid;
      ex_mem.reg_wr <= id_ex.reg_wr;
      ex_mem.mem_rd <= id_ex.mem_rd;
      ex_mem.mem_wr <= id_ex.mem_wr;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem.alu_result <= result;
    ex_mem.store_data <= reg_b;
    ex_mem.dest       <= id_ex.dest;
    ex_mem.pc         <= id_ex.pc;
  end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
  parameter int imem_words = 256
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stall,
  input  logic                      br_taken,
  input  logic [mips_pkg::xlen-1:0] br_target,
  input  logic                      imem_we,
  input  logic [mips_pkg::xlen-1:0] imem_addr,
  input  logic [mips_pkg::xlen-1:0] imem_wdata,
  output logic [mips_pkg::xlen-1:0] id_instr,
  output logic [mips_pkg::xlen-1:0] id_pc,
  output logic                      id_valid
);

  localparam int idx_w = $clog2(imem_words);

  logic [mips_pkg::xlen-1:0] imem [imem_words];
  logic [mips_pkg::xlen-1:0] pc;
  logic [mips_pkg::xlen-1:0] pc_next;
  logic [mips_pkg::xlen-1:0] if_instr;

  assign if_instr = imem[pc[idx_w+1:2]];
  // branch target arrives while the delay slot is being fetched
  assign pc_next  = br_taken ? br_target : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pc_next;
    end
  end

  // program load port
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr[idx_w+1:2]] <= imem_wdata;
    end
  end

  // IF/ID register holds on stall
  always_ff @(posedge clk) begin
    if (reset) begin
      id_valid <= 1'b0;
      id_instr <= '0;
      id_pc    <= '0;
    end else if (!stall) begin
      id_valid <= 1'b1;
      id_instr <= if_instr;
      id_pc    <= pc;
    end
  end

  a_load_in_reset: assert property (@(posedge clk) imem_we |-> reset)
    else $error("instruction memory written outside reset");

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      id_valid,
  input  logic [mips_pkg::xlen-1:0] id_instr,
  id_ex_if.monitor                  id_ex,
  ex_mem_if.monitor                 ex_mem,
  output logic                      stall,
  output logic                      br_fwd_a,
  output logic                      br_fwd_b
);

  mips_pkg::opcode_e               opcode;
  logic [mips_pkg::reg_addr_w-1:0] rs;
  logic [mips_pkg::reg_addr_w-1:0] rt;
  logic                            uses_rs;
  logic                            uses_rt;
  logic                            is_br;
  logic                            ex_dep;
  logic                            mem_dep;

  assign opcode = mips_pkg::opcode_e'(id_instr[mips_pkg::op_lsb +: 6]);
  assign rs     = id_instr[mips_pkg::rs_lsb +: mips_pkg::reg_addr_w];
  assign rt     = id_instr[mips_pkg::rt_lsb +: mips_pkg::reg_addr_w];

  // which source fields the ID instruction really reads
  always_comb begin
    uses_rs = 1'b0;
    uses_rt = 1'b0;
    is_br   = 1'b0;
    case (opcode)
      mips_pkg::op_special, mips_pkg::op_sw: begin
        uses_rs = 1'b1;
        uses_rt = 1'b1;
      end
      mips_pkg::op_beq, mips_pkg::op_bne: begin
        uses_rs = 1'b1;
        uses_rt = 1'b1;
        is_br   = 1'b1;
      end
      mips_pkg::op_addiu, mips_pkg::op_ori, mips_pkg::op_lw: uses_rs = 1'b1;
      default: ;
    endcase
  end

  // decode never sets reg_wr with dest 0
  assign ex_dep  = id_ex.reg_wr &&
                   ((uses_rs && id_ex.dest == rs) || (uses_rt && id_ex.dest == rt));
  assign mem_dep = ex_mem.reg_wr &&
                   ((uses_rs && ex_mem.dest == rs) || (uses_rt && ex_mem.dest == rt));

  // load-use, branch on EX result, branch on load still in MEM
  assign stall = (ex_dep && (id_ex.mem_rd || is_br)) || (is_br && mem_dep && ex_mem.mem_rd);

  assign br_fwd_a = ex_mem.reg_wr && !ex_mem.mem_rd && ex_mem.dest == rs;
  assign br_fwd_b = ex_mem.reg_wr && !ex_mem.mem_rd && ex_mem.dest == rt;

  a_stall_valid: assert property (@(posedge clk) disable iff (reset) stall |-> id_valid)
    else $error("stall raised for an empty decode stage");

endmodule

// File: logic/memory_unit.sv
`timescale 1ns/10ps

module memory_unit #(
  parameter int dmem_words = 256
) (
  input  logic                      clk,
  input  logic                      reset,
  ex_mem_if.consumer                ex_mem,
  mem_wb_if.producer                mem_wb,
  input  logic [mips_pkg::xlen-1:0] mem_addr,
  output logic [mips_pkg::xlen-1:0] mem_data
);

  localparam int idx_w = $clog2(dmem_words);

  logic [mips_pkg::xlen-1:0] dmem [dmem_words];
  logic [idx_w-1:0]          idx;
  logic [mips_pkg::xlen-1:0] load_word;

  // word addressed with the low two bits ignored
  assign idx       = ex_mem.alu_result[idx_w+1:2];
  assign load_word = dmem[idx];
  assign mem_data  = dmem[mem_addr[idx_w+1:2]];

  always_ff @(posedge clk) begin
    if (ex_mem.mem_wr) begin
      dmem[idx] <= ex_mem.store_data;
    end
  end

  // MEM/WB register
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb.valid  <= 1'b0;
      mem_wb.reg_wr <= 1'b0;
    end else begin
      mem_wb.valid  <= ex_mem.valid;
      mem_wb.reg_wr <= ex_mem.reg_wr;
    end
  end

  always_ff @(posedge clk) begin
    mem_wb.wdata <= ex_mem.mem_rd ? load_word : ex_mem.alu_result;
    mem_wb.dest  <= ex_mem.dest;
    mem_wb.pc    <= ex_mem.pc;
  end

  a_rd_wr_excl: assert property (
    @(posedge clk) disable iff (reset) !(ex_mem.mem_rd && ex_mem.mem_wr)
  ) else $error("memory access both reads and writes");

endmodule

// File: logic/mips_pkg.sv
package mips_pkg;

  parameter int xlen = 32;
  parameter int reg_addr_w = 5;

  // instruction field positions
  parameter int op_lsb = 26;
  parameter int rs_lsb = 21;
  parameter int rt_lsb = 16;
  parameter int rd_lsb = 11;
  parameter int shamt_lsb = 6;
  parameter int imm_w = 16;
  parameter int target_w = 26;

  typedef enum logic [5:0] {
    op_special = 6'h00,
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_ori     = 6'h0d,
    op_lui     = 6'h0f,
    op_lw      = 6'h23,
    op_sw      = 6'h2b
  } opcode_e;

  // funct field of special opcode
  typedef enum logic [5:0] {
    fn_sll  = 6'h00,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_slt  = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt,
    alu_sll,
    alu_lui
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_rf  = 2'd0,
    fwd_mem = 2'd1,
    fwd_wb  = 2'd2
  } fwd_sel_e;

endpackage

// File: logic/mips_top.sv
`timescale 1ns/10ps

module mips_top (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            imem_we,
  input  logic [mips_pkg::xlen-1:0]       imem_addr,
  input  logic [mips_pkg::xlen-1:0]       imem_wdata,
  input  logic [mips_pkg::reg_addr_w-1:0] rf_addr,
  output logic [mips_pkg::xlen-1:0]       rf_data,
  input  logic [mips_pkg::xlen-1:0]       mem_addr,
  output logic [mips_pkg::xlen-1:0]       mem_data,
  output logic [mips_pkg::xlen-1:0]       wb_pc,
  output logic                            wb_valid
);

  localparam int imem_words = 256;
  localparam int dmem_words = 256;

  logic                      stall;
  logic                      br_taken;
  logic [mips_pkg::xlen-1:0] br_target;
  logic                      br_fwd_a;
  logic                      br_fwd_b;
  logic [mips_pkg::xlen-1:0] id_instr;
  logic [mips_pkg::xlen-1:0] id_pc;
  logic                      id_valid;

  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();
  mem_wb_if mem_wb ();

  fetch_unit #(.imem_words(imem_words)) u_fetch (
    .clk, .reset, .stall, .br_taken, .br_target,
    .imem_we, .imem_addr, .imem_wdata,
    .id_instr, .id_pc, .id_valid
  );

  decode_unit u_decode (
    .clk, .reset, .id_instr, .id_pc, .id_valid, .stall,
    .br_fwd_a, .br_fwd_b, .br_taken, .br_target,
    .rf_addr, .rf_data,
    .id_ex(id_ex.producer), .ex_mem(ex_mem.monitor), .mem_wb(mem_wb.consumer)
  );

  hazard_unit u_hazard (
    .clk, .reset, .id_valid, .id_instr,
    .id_ex(id_ex.monitor), .ex_mem(ex_mem.monitor),
    .stall, .br_fwd_a, .br_fwd_b
  );

  execute_unit u_execute (
    .clk, .reset,
    .id_ex(id_ex.consumer), .ex_mem(ex_mem.producer), .mem_wb(mem_wb.consumer)
  );

  memory_unit #(.dmem_words(dmem_words)) u_memory (
    .clk, .reset,
    .ex_mem(ex_mem.consumer), .mem_wb(mem_wb.producer),
    .mem_addr, .mem_data
  );

  // retirement display
  assign wb_pc    = mem_wb.pc;
  assign wb_valid = mem_wb.valid;

endmodule

// File: logic/pipe_ifs.sv
`timescale 1ns/10ps

// decode to execute
interface id_ex_if;
  logic [mips_pkg::reg_addr_w-1:0] rs;
  logic [mips_pkg::reg_addr_w-1:0] rt;
  logic [mips_pkg::reg_addr_w-1:0] dest;
  logic [mips_pkg::xlen-1:0]       a;
  logic [mips_pkg::xlen-1:0]       b;
  logic [mips_pkg::xlen-1:0]       imm;
  logic [4:0]                      shamt;
  mips_pkg::alu_op_e               alu_op;
  logic                            alu_src_imm;
  logic                            reg_wr;
  logic                            mem_rd;
  logic                            mem_wr;
  logic [mips_pkg::xlen-1:0]       pc;
  logic                            valid;

  modport producer (output rs, rt, dest, a, b, imm, shamt, alu_op, alu_src_imm,
                    reg_wr, mem_rd, mem_wr, pc, valid);
  modport consumer (input rs, rt, dest, a, b, imm, shamt, alu_op, alu_src_imm,
                    reg_wr, mem_rd, mem_wr, pc, valid);
  modport monitor (input dest, reg_wr, mem_rd);
endinterface

// execute to memory
interface ex_mem_if;
  logic [mips_pkg::xlen-1:0]       alu_result;
  logic [mips_pkg::xlen-1:0]       store_data;
  logic [mips_pkg::reg_addr_w-1:0] dest;
  logic                            reg_wr;
  logic                            mem_rd;
  logic                            mem_wr;
  logic [mips_pkg::xlen-1:0]       pc;
  logic                            valid;

  modport producer (output alu_result, store_data, dest, reg_wr, mem_rd, mem_wr, pc, valid);
  modport consumer (input alu_result, store_data, dest, reg_wr, mem_rd, mem_wr, pc, valid);
  modport monitor (input alu_result, dest, reg_wr, mem_rd);
endinterface

// memory to write-back
interface mem_wb_if;
  logic [mips_pkg::xlen-1:0]       wdata;
  logic [mips_pkg::reg_addr_w-1:0] dest;
  logic                            reg_wr;
  logic [mips_pkg::xlen-1:0]       pc;
  logic                            valid;

  modport producer (output wdata, dest, reg_wr, pc, valid);
  modport consumer (input wdata, dest, reg_wr, pc, valid);
endinterface

// File: run.sh
#!/bin/sh
# build and run the pipelined MIPS testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f src.f --top-module mips_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vmips_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides pass or fail
if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1

// File: src.f
logic/mips_pkg.sv
logic/pipe_ifs.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/hazard_unit.sv
logic/execute_unit.sv
logic/memory_unit.sv
logic/mips_top.sv
dv/mips_checker.sv
dv/mips_tb.sv
